// ==== Bender.yml ====
package:
  name: branch_resolve

export_include_dirs:
  - include

sources:
  - files:
      - hdl/branch_pkg.sv
      - hdl/branch_target_if.sv
      - hdl/branch_cmp.sv
      - hdl/branch_target.sv
      - hdl/branch_unit.sv
      - hdl/branch_resolve_top.sv
  - target: test
    files:
      - test/tb_branch_resolve.sv

// ==== hdl/branch_cmp.sv ====
// operand comparator for the execute stage, gives the taken decision for the current opcode
`timescale 1ns/1ps
`default_nettype none

`include "branch_macros.svh"

module branch_cmp (
    input  branch_pkg::br_op_e  op_i,
    input  logic [`BR_VLEN-1:0] operand_a_i,
    input  logic [`BR_VLEN-1:0] operand_b_i,
    output logic                taken_o
);

    logic is_equal;
    logic is_less_signed;
    logic is_less_unsigned;

    // all three relations are formed in parallel and the opcode selects one
    assign is_equal         = (operand_a_i == operand_b_i);
    assign is_less_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
    assign is_less_unsigned = (operand_a_i < operand_b_i);

    always_comb begin : taken_select
        // unconditional jumps are always taken
        taken_o = 1'b1;
        if (branch_pkg::op_is_branch(op_i)) begin
            case (op_i)
                branch_pkg::BEQ: begin
                    taken_o = is_equal;
                end
                branch_pkg::BNE: begin
                    taken_o = !is_equal;
                end
                branch_pkg::BLT: begin
                    taken_o = is_less_signed;
                end
                // greater or equal is the inverse of less-than
                branch_pkg::BGE: begin
                    taken_o = !is_less_signed;
                end
                branch_pkg::BLTU: begin
                    taken_o = is_less_unsigned;
                end
                default: begin
                    taken_o = !is_less_unsigned;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/branch_pkg.sv ====
// shared opcode and control-flow types for the branch resolution blocks, referenced by scoped name
`default_nettype none

`include "branch_macros.svh"

package branch_pkg;

    // control-flow opcodes handled by the execute-stage branch resolution
    typedef enum logic [`BR_OP_W-1:0] {
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        JAL,
        JALR
    } br_op_e;

    // control-flow type, used for the front end's prediction and for predictor update
    typedef enum logic [`BR_CF_W-1:0] {
        NO_CF,
        BRANCH,
        JUMP,
        JUMP_R,
        RETURN
    } cf_type_e;

    // true for the six conditional branches, false for JAL and JALR
    function automatic logic op_is_branch(br_op_e op);
        return (op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU});
    endfunction

endpackage

`default_nettype wire

// ==== hdl/branch_resolve_top.sv ====
// top level of the branch resolution subsystem, plain ports around comparator, target and unit
`timescale 1ns/1ps
`default_nettype none

`include "branch_macros.svh"

module branch_resolve_top (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    // instruction fields, valid for one cycle with valid_i
    input  logic                     valid_i,
    input  branch_pkg::br_op_e       op_i,
    input  logic [`BR_VLEN-1:0]      pc_i,
    input  logic [`BR_VLEN-1:0]      operand_a_i,
    input  logic [`BR_VLEN-1:0]      operand_b_i,
    input  logic [`BR_VLEN-1:0]      imm_i,
    input  logic                     is_compressed_i,
    // prediction made by the front end for this instruction
    input  branch_pkg::cf_type_e     predict_cf_i,
    input  logic [`BR_VLEN-1:0]      predict_address_i,
    // resolution, one cycle after valid_i
    output logic                     resolve_valid_o,
    output logic [`BR_VLEN-1:0]      resolved_pc_o,
    output logic [`BR_VLEN-1:0]      resolved_target_o,
    output logic                     is_taken_o,
    output logic                     is_mispredict_o,
    output branch_pkg::cf_type_e     cf_type_o,
    output logic [`BR_VLEN-1:0]      link_result_o,
    // misaligned instruction address exception
    output logic                     exception_valid_o,
    output logic [`BR_VLEN-1:0]      exception_tval_o
);

    logic taken;

    // target calculator results shared with the branch unit
    branch_target_if target_bus ();

    branch_cmp u_branch_cmp (
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .taken_o     (taken)
    );

    branch_target u_branch_target (
        .op_i              (op_i),
        .pc_i              (pc_i),
        .operand_a_i       (operand_a_i),
        .imm_i             (imm_i),
        .is_compressed_i   (is_compressed_i),
        .predict_address_i (predict_address_i),
        .target            (target_bus.producer)
    );

    // the only register stage of the subsystem
    branch_unit u_branch_unit (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .valid_i           (valid_i),
        .op_i              (op_i),
        .pc_i              (pc_i),
        .taken_i           (taken),
        .predict_cf_i      (predict_cf_i),
        .target            (target_bus.consumer),
        .resolve_valid_o   (resolve_valid_o),
        .resolved_pc_o     (resolved_pc_o),
        .resolved_target_o (resolved_target_o),
        .is_taken_o        (is_taken_o),
        .is_mispredict_o   (is_mispredict_o),
        .cf_type_o         (cf_type_o),
        .link_result_o     (link_result_o),
        .exception_valid_o (exception_valid_o),
        .exception_tval_o  (exception_tval_o)
    );

endmodule

`default_nettype wire

// ==== hdl/branch_target.sv ====
// jump target and next PC calculation with alignment and prediction checks, no register stage
`timescale 1ns/1ps
`default_nettype none

`include "branch_macros.svh"

module branch_target (
    input  branch_pkg::br_op_e   op_i,
    input  logic [`BR_VLEN-1:0]  pc_i,
    input  logic [`BR_VLEN-1:0]  operand_a_i,
    input  logic [`BR_VLEN-1:0]  imm_i,
    input  logic                 is_compressed_i,
    input  logic [`BR_VLEN-1:0]  predict_address_i,
    branch_target_if.producer    target
);

    logic [`BR_VLEN-1:0] jump_base;
    logic [`BR_VLEN-1:0] target_sum;
    logic [`BR_VLEN-1:0] target_addr;
    logic [`BR_VLEN-1:0] pc_step;

    // JALR jumps relative to a register, every other control-flow instruction relative to the PC
    assign jump_base = (op_i == branch_pkg::JALR) ? operand_a_i : pc_i;

    // the immediate is already sign extended to full width by decode
    assign target_sum = $unsigned($signed(jump_base) + $signed(imm_i));

    always_comb begin : target_align
        target_addr = target_sum;
        // JALR drops the lowest bit of the sum
        if (op_i == branch_pkg::JALR) begin
            target_addr[0] = 1'b0;
        end
    end

    // compressed instructions are two bytes long, full-size ones four
    assign pc_step = is_compressed_i ? `BR_VLEN'(`BR_STEP_RVC) : `BR_VLEN'(`BR_STEP_RVI);

    assign target.target_addr = target_addr;
    assign target.next_pc     = pc_i + pc_step;

    // with compressed support only bit 0 has to be clear for a legal fetch address
    assign target.target_misaligned = target_addr[0];

    // the front end's guess is compared against the full computed target
    assign target.predict_hit = (target_addr == predict_address_i);

endmodule

`default_nettype wire

// ==== hdl/branch_target_if.sv ====
// bundle carrying the target calculator's results to the branch unit within one cycle
`timescale 1ns/1ps
`default_nettype none

`include "branch_macros.svh"

interface branch_target_if;

    // jump base plus immediate, bit 0 already cleared for JALR
    logic [`BR_VLEN-1:0] target_addr;
    // sequential PC, the link value for rd
    logic [`BR_VLEN-1:0] next_pc;
    // target is not on a 2 byte boundary
    logic                target_misaligned;
    // target matches the address the front end predicted
    logic                predict_hit;

    modport producer (output target_addr, output next_pc, output target_misaligned,
                      output predict_hit);

    modport consumer (input target_addr, input next_pc, input target_misaligned,
                      input predict_hit);

endinterface

`default_nettype wire

// ==== hdl/branch_unit.sv ====
// combines comparison, target and prediction into the registered branch resolution and exception
`timescale 1ns/1ps
`default_nettype none

`include "branch_macros.svh"

module branch_unit (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     valid_i,
    input  branch_pkg::br_op_e       op_i,
    input  logic [`BR_VLEN-1:0]      pc_i,
    input  logic                     taken_i,
    input  branch_pkg::cf_type_e     predict_cf_i,
    branch_target_if.consumer        target,
    output logic                     resolve_valid_o,
    output logic [`BR_VLEN-1:0]      resolved_pc_o,
    output logic [`BR_VLEN-1:0]      resolved_target_o,
    output logic                     is_taken_o,
    output logic                     is_mispredict_o,
    output branch_pkg::cf_type_e     cf_type_o,
    output logic [`BR_VLEN-1:0]      link_result_o,
    output logic                     exception_valid_o,
    output logic [`BR_VLEN-1:0]      exception_tval_o
);

    logic [`BR_VLEN-1:0]  resolved_target_d;
    logic                 is_mispredict_d;
    branch_pkg::cf_type_e cf_type_d;
    logic                 exception_valid_d;

    // a not-taken instruction continues at the sequential PC
    assign resolved_target_d = taken_i ? target.target_addr : target.next_pc;

    always_comb begin : mispredict_check
        // the predicted type is kept unless the outcome says otherwise
        cf_type_d       = predict_cf_i;
        is_mispredict_d = 1'b0;

        // conditional branches update the history table, so their type is always BRANCH
        // a mispredict is any disagreement between the outcome and a BRANCH prediction
        if (branch_pkg::op_is_branch(op_i)) begin
            cf_type_d       = branch_pkg::BRANCH;
            is_mispredict_d = (taken_i != (predict_cf_i == branch_pkg::BRANCH));
        end

        // JAL has a PC-relative target known at fetch and is never mispredicted

        // JALR is wrong when nothing was predicted or the predicted address differs
        if (op_i == branch_pkg::JALR &&
            (predict_cf_i == branch_pkg::NO_CF || !target.predict_hit)) begin
            is_mispredict_d = 1'b1;
            // returns come from the return stack and must not be written into the target buffer
            if (predict_cf_i != branch_pkg::RETURN) begin
                cf_type_d = branch_pkg::JUMP_R;
            end
        end
    end

    // a misaligned target raises the fetch exception even for a not-taken branch
    assign exception_valid_d = valid_i && target.target_misaligned;

    // the strobes follow valid_i by exactly one cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin : valid_reg
        if (!arst_n_i) begin
            resolve_valid_o   <= 1'b0;
            exception_valid_o <= 1'b0;
        end else begin
            resolve_valid_o   <= valid_i;
            exception_valid_o <= exception_valid_d;
        end
    end

    // the result fields only load for a valid instruction and hold otherwise
    always_ff @(posedge clk_i or negedge arst_n_i) begin : result_reg
        if (!arst_n_i) begin
            resolved_pc_o     <= '0;
            resolved_target_o <= '0;
            is_taken_o        <= 1'b0;
            is_mispredict_o   <= 1'b0;
            cf_type_o         <= branch_pkg::NO_CF;
            link_result_o     <= '0;
            exception_tval_o  <= '0;
        end else if (valid_i) begin
            resolved_pc_o     <= pc_i;
            resolved_target_o <= resolved_target_d;
            is_taken_o        <= taken_i;
            is_mispredict_o   <= is_mispredict_d;
            cf_type_o         <= cf_type_d;
            // rd receives the return address for JAL and JALR
            link_result_o     <= target.next_pc;
            // tval reports the PC of the faulting jump, not the bad target
            exception_tval_o  <= pc_i;
        end
    end

endmodule

`default_nettype wire

// ==== include/branch_macros.svh ====
// width macros for the branch resolution subsystem, included by the RTL and the testbench

`ifndef BRANCH_MACROS_SVH
`define BRANCH_MACROS_SVH

// width of PCs, register operands, immediates and jump targets
// the datapath also works with a 64 bit setting
`define BR_VLEN 32

// encoding width of the opcode enum in the package
`define BR_OP_W 4

// encoding width of the control-flow type enum in the package
`define BR_CF_W 3

// byte step to the next sequential PC for compressed and full-size instructions
`define BR_STEP_RVC 2
`define BR_STEP_RVI 4

`endif

// ==== src.f ====
+incdir+include
hdl/branch_pkg.sv
hdl/branch_target_if.sv
hdl/branch_cmp.sv
hdl/branch_target.sv
hdl/branch_unit.sv
hdl/branch_resolve_top.sv
test/tb_branch_resolve.sv

// ==== test/tb_branch_resolve.sv ====
// self-checking testbench for the branch resolution top level, run from the file list with uut as DUT
`timescale 1ns/1ps
`default_nettype none

`include "branch_macros.svh"

module tb_branch_resolve;

    localparam int unsigned RANDOM_SEED = 32'h6def891e;
    localparam int NUM_INSTR = 2000;
    // about 4/3 cycles per instruction at the 3/4 valid rate, so twice the count leaves room
    localparam int MAX_CYCLES = 2 * NUM_INSTR;

    logic clk_i;
    logic arst_n_i;
    logic valid_i;
    branch_pkg::br_op_e op_i;
    logic [`BR_VLEN-1:0] pc_i;
    logic [`BR_VLEN-1:0] operand_a_i;
    logic [`BR_VLEN-1:0] operand_b_i;
    logic [`BR_VLEN-1:0] imm_i;
    logic is_compressed_i;
    branch_pkg::cf_type_e predict_cf_i;
    logic [`BR_VLEN-1:0] predict_address_i;
    logic resolve_valid_o;
    logic [`BR_VLEN-1:0] resolved_pc_o;
    logic [`BR_VLEN-1:0] resolved_target_o;
    logic is_taken_o;
    logic is_mispredict_o;
    branch_pkg::cf_type_e cf_type_o;
    logic [`BR_VLEN-1:0] link_result_o;
    logic exception_valid_o;
    logic [`BR_VLEN-1:0] exception_tval_o;

    // the model_ values are the reference model's outputs for the current inputs
    // the exp_ values are registered one cycle later like the DUT
    logic model_taken;
    logic model_mispredict;
    branch_pkg::cf_type_e model_cf;
    logic [`BR_VLEN-1:0] model_target;
    logic [`BR_VLEN-1:0] model_next_pc;
    logic exp_resolve_valid;
    logic exp_exception_valid;
    logic exp_taken;
    logic exp_mispredict;
    branch_pkg::cf_type_e exp_cf;
    logic [`BR_VLEN-1:0] exp_pc;
    logic [`BR_VLEN-1:0] exp_target;
    logic [`BR_VLEN-1:0] exp_link;
    logic [`BR_VLEN-1:0] exp_tval;

    int sent_count;
    int resolved_count;
    int cycle_count;

    branch_resolve_top uut (.*);

    always #4 clk_i = !clk_i;

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] expected);
        $display("mismatch %s got 0x%0h expected 0x%0h", name, got, expected);
        $display("Checks failed");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "stopped at the first failing check");
    endtask

    // RISC-V conditional branch decision rules where the jumps are always taken
    function automatic logic expected_taken(input branch_pkg::br_op_e op,
                                            input logic [`BR_VLEN-1:0] a,
                                            input logic [`BR_VLEN-1:0] b);
        case (op)
            branch_pkg::BEQ:  return a == b;
            branch_pkg::BNE:  return a != b;
            branch_pkg::BLT:  return $signed(a) < $signed(b);
            branch_pkg::BGE:  return $signed(a) >= $signed(b);
            branch_pkg::BLTU: return a < b;
            branch_pkg::BGEU: return a >= b;
            default:          return 1'b1;
        endcase
    endfunction

    // JALR adds to the register and drops bit 0
    // everything else is PC relative
    function automatic logic [`BR_VLEN-1:0] expected_target(input branch_pkg::br_op_e op,
                                                           input logic [`BR_VLEN-1:0] pc,
                                                           input logic [`BR_VLEN-1:0] a,
                                                           input logic [`BR_VLEN-1:0] imm);
        logic [`BR_VLEN-1:0] sum;
        sum = (op == branch_pkg::JALR) ? a + imm : pc + imm;
        if (op == branch_pkg::JALR) begin
            sum[0] = 1'b0;
        end
        return sum;
    endfunction

    // operands lean toward zero, all ones and the two sign boundary values
    function automatic logic [`BR_VLEN-1:0] pick_operand();
        case ($urandom_range(0, 7))
            0:       return '0;
            1:       return '1;
            2:       return {1'b1, {(`BR_VLEN-1){1'b0}}};
            3:       return {1'b0, {(`BR_VLEN-1){1'b1}}};
            4:       return `BR_VLEN'(1);
            default: return `BR_VLEN'({$urandom, $urandom});
        endcase
    endfunction

    always_comb begin : reference_model
        model_taken      = expected_taken(op_i, operand_a_i, operand_b_i);
        model_target     = expected_target(op_i, pc_i, operand_a_i, imm_i);
        model_next_pc    = pc_i + (is_compressed_i ? `BR_VLEN'(2) : `BR_VLEN'(4));
        model_cf         = predict_cf_i;
        model_mispredict = 1'b0;
        case (op_i)
            branch_pkg::JAL: begin
                model_mispredict = 1'b0;
            end
            branch_pkg::JALR: begin
                // a missing prediction or a wrong address both count as a miss
                if (predict_cf_i == branch_pkg::NO_CF || model_target != predict_address_i) begin
                    model_mispredict = 1'b1;
                    model_cf = (predict_cf_i == branch_pkg::RETURN) ? branch_pkg::RETURN
                                                                    : branch_pkg::JUMP_R;
                end
            end
            default: begin
                model_cf         = branch_pkg::BRANCH;
                model_mispredict = model_taken != (predict_cf_i == branch_pkg::BRANCH);
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin : reference_regs
        if (!arst_n_i) begin
            exp_resolve_valid   <= 1'b0;
            exp_exception_valid <= 1'b0;
            exp_taken           <= 1'b0;
            exp_mispredict      <= 1'b0;
            exp_cf              <= branch_pkg::NO_CF;
            exp_pc              <= '0;
            exp_target          <= '0;
            exp_link            <= '0;
            exp_tval            <= '0;
        end else begin
            exp_resolve_valid   <= valid_i;
            exp_exception_valid <= valid_i && model_target[0];
            // data fields keep the last resolved instruction on idle cycles
            if (valid_i) begin
                exp_taken      <= model_taken;
                exp_mispredict <= model_mispredict;
                exp_cf         <= model_cf;
                exp_pc         <= pc_i;
                exp_target     <= model_taken ? model_target : model_next_pc;
                exp_link       <= model_next_pc;
                exp_tval       <= pc_i;
            end
        end
    end

    // all checks sample on the falling edge, half a cycle away from any input or output change
    assert property (@(negedge clk_i) !arst_n_i |-> !resolve_valid_o && !exception_valid_o)
        else report_failure("a valid flag was high while reset was asserted");
    assert property (@(negedge clk_i) disable iff (!arst_n_i) resolve_valid_o == exp_resolve_valid)
        else report_mismatch("resolve_valid_o", resolve_valid_o, exp_resolve_valid);
    assert property (@(negedge clk_i) disable iff (!arst_n_i) resolved_pc_o == exp_pc)
        else report_mismatch("resolved_pc_o", resolved_pc_o, exp_pc);
    assert property (@(negedge clk_i) disable iff (!arst_n_i) resolved_target_o == exp_target)
        else report_mismatch("resolved_target_o", resolved_target_o, exp_target);
    assert property (@(negedge clk_i) disable iff (!arst_n_i) is_taken_o == exp_taken)
        else report_mismatch("is_taken_o", is_taken_o, exp_taken);
    assert property (@(negedge clk_i) disable iff (!arst_n_i) is_mispredict_o == exp_mispredict)
        else report_mismatch("is_mispredict_o", is_mispredict_o, exp_mispredict);
    assert property (@(negedge clk_i) disable iff (!arst_n_i) cf_type_o == exp_cf)
        else report_mismatch("cf_type_o", cf_type_o, exp_cf);
    assert property (@(negedge clk_i) disable iff (!arst_n_i) link_result_o == exp_link)
        else report_mismatch("link_result_o", link_result_o, exp_link);
    assert property (@(negedge clk_i) disable iff (!arst_n_i)
                     exception_valid_o == exp_exception_valid)
        else report_mismatch("exception_valid_o", exception_valid_o, exp_exception_valid);
    assert property (@(negedge clk_i) disable iff (!arst_n_i) exception_tval_o == exp_tval)
        else report_mismatch("exception_tval_o", exception_tval_o, exp_tval);

    always @(negedge clk_i) begin : count_resolved
        if (arst_n_i && resolve_valid_o) begin
            resolved_count <= resolved_count + 1;
        end
    end

    always @(posedge clk_i) begin : watchdog
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            report_failure("timeout, the run did not finish within the cycle limit");
        end
    end

    // draws one instruction and drives it
    // the fields also change on idle cycles
    task automatic drive_random_instruction(input logic valid);
        branch_pkg::br_op_e op;
        logic [`BR_VLEN-1:0] a;
        logic [`BR_VLEN-1:0] pc;
        logic [`BR_VLEN-1:0] imm;
        logic signed [11:0] imm_short;
        op = branch_pkg::br_op_e'(4'($urandom_range(0, 7)));
        a = pick_operand();
        pc = `BR_VLEN'({$urandom, $urandom});
        pc[0] = 1'b0;
        imm_short = 12'($urandom);
        // mostly even offsets, an odd one now and then to reach the misaligned case
        if ($urandom_range(0, 7) != 0) begin
            imm_short[0] = 1'b0;
        end
        imm = {{(`BR_VLEN-12){imm_short[11]}}, imm_short};
        valid_i         <= valid;
        op_i            <= op;
        pc_i            <= pc;
        operand_a_i     <= a;
        operand_b_i     <= ($urandom_range(0, 3) == 0) ? a : pick_operand();
        imm_i           <= imm;
        is_compressed_i <= 1'($urandom);
        predict_cf_i    <= branch_pkg::cf_type_e'(3'($urandom_range(0, 4)));
        // the predicted address is right on most draws
        predict_address_i <= ($urandom_range(0, 7) != 0) ? expected_target(op, pc, a, imm)
                                                         : `BR_VLEN'({$urandom, $urandom});
    endtask

    initial begin
        void'($urandom(RANDOM_SEED));
        clk_i             = 1'b0;
        arst_n_i          = 1'b0;
        valid_i           = 1'b0;
        op_i              = branch_pkg::BEQ;
        pc_i              = '0;
        operand_a_i       = '0;
        operand_b_i       = '0;
        imm_i             = '0;
        is_compressed_i   = 1'b0;
        predict_cf_i      = branch_pkg::NO_CF;
        predict_address_i = '0;
        sent_count        = 0;
        resolved_count    = 0;
        cycle_count       = 0;
        repeat (10) @(posedge clk_i);
        arst_n_i <= 1'b1;
        while (sent_count < NUM_INSTR) begin
            @(posedge clk_i);
            if ($urandom_range(0, 3) != 0) begin
                drive_random_instruction(1'b1);
                sent_count = sent_count + 1;
            end else begin
                drive_random_instruction(1'b0);
            end
        end
        @(posedge clk_i);
        valid_i <= 1'b0;
        // let the last result leave and be counted
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        if (resolved_count != sent_count) begin
            report_mismatch("resolve_valid_o pulse count", resolved_count, sent_count);
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
